// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := instr_parse_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/instr_parse_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_parse_tb;

    localparam int N_ROWS     = 15;
    localparam int BUF_WORDS  = 64;
    localparam int RST_CYCLES = 4;
    localparam int MAX_CYCLES = N_ROWS * (instr_proto_pkg::HDR_WORDS
                                + instr_proto_pkg::MAX_PAYLOAD + 10) + RST_CYCLES;

    typedef struct packed {
        instr_proto_pkg::word_t      id_word;
        instr_proto_pkg::word_t      pkt_cnt;
        instr_proto_pkg::cmd_t       cmd;
        instr_proto_pkg::word_idx_t  n_beats;
        instr_core_pkg::gap_report_t gap;
        logic                        link_after;
    } frame_row_t;

    logic                          sys_clk     = 1'b0;
    logic                          rst_n       = 1'b0;
    logic                          frame_ready = 1'b0;
    instr_proto_pkg::word_t        rd_data     = '0;
    instr_proto_pkg::buf_addr_t    rd_addr;
    logic                          busy;
    logic                          link_up;
    instr_core_pkg::payload_beat_t beat;
    instr_core_pkg::gap_report_t   gap;

    instr_proto_pkg::word_t mem [BUF_WORDS];
    frame_row_t             rows [N_ROWS];
    logic [31:0]            seed;
    int                     cycles = 0;

    instr_parse_top dut0 (
        .i_sys_clk     (sys_clk),
        .i_rst_n       (rst_n),
        .i_frame_ready (frame_ready),
        .o_rd_addr     (rd_addr),
        .i_rd_data     (rd_data),
        .o_busy        (busy),
        .o_link_up     (link_up),
        .o_beat        (beat),
        .o_gap         (gap)
    );

    always #2 sys_clk = ~sys_clk;

    // buffer model answers one edge after the address
    always @(posedge sys_clk) begin
        if (rd_addr < instr_proto_pkg::buf_addr_t'(BUF_WORDS)) begin
            rd_data <= mem[rd_addr[5:0]];
        end else begin
            rd_data <= {16'hbad0, rd_addr};
        end
    end

    // --------------------
    // reporting and compares

    task automatic report_failure(input string what);
        $display("%s at %0t ns", what, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_failure("timeout, the parser did not finish within the cycle limit");
        end
    end

    task automatic check_beat(input instr_core_pkg::payload_beat_t exp,
                              input instr_core_pkg::payload_beat_t act);
        if (act.cmd !== exp.cmd) begin
            report_mismatch("o_beat.cmd", 32'(exp.cmd), 32'(act.cmd));
        end else if (act.idx !== exp.idx) begin
            report_mismatch("o_beat.idx", 32'(exp.idx), 32'(act.idx));
        end else if (act.data !== exp.data) begin
            report_mismatch("o_beat.data", exp.data, act.data);
        end
    endtask

    task automatic check_gap(input instr_core_pkg::gap_report_t exp,
                             input instr_core_pkg::gap_report_t act);
        if (act.valid !== exp.valid) begin
            report_mismatch("o_gap.valid", 32'(exp.valid), 32'(act.valid));
        end else if (exp.valid && act.missing !== exp.missing) begin
            report_mismatch("o_gap.missing", exp.missing, act.missing);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch(name, 32'(exp), 32'(act));
        end
    endtask

    // --------------------
    // stimulus

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic frame_row_t row_of(input logic [31:0] id_word, input logic [31:0] cnt,
                                          input instr_proto_pkg::cmd_t cmd, input logic [4:0] n,
                                          input logic gap_valid, input logic [31:0] missing,
                                          input logic link_after);
        frame_row_t r;
        r.id_word     = id_word;
        r.pkt_cnt     = cnt;
        r.cmd         = cmd;
        r.n_beats     = n;
        r.gap.valid   = gap_valid;
        r.gap.missing = missing;
        r.link_after  = link_after;
        return r;
    endfunction

    // id word, counter, cmd, beats, gap valid, missing, link afterwards
    task automatic load_table();
        rows[0]  = row_of({24'd0, instr_proto_pkg::ID_DOF}, 32'd1,
                          instr_proto_pkg::CMD_NONE, 5'd0, 1'b0, 32'd0, 1'b0);
        rows[1]  = row_of({24'd0, instr_proto_pkg::ID_CONNECT}, 32'd2,
                          instr_proto_pkg::CMD_NONE, 5'd0, 1'b0, 32'd0, 1'b1);
        rows[2]  = row_of({24'd0, instr_proto_pkg::ID_DOF}, 32'd3,
                          instr_proto_pkg::CMD_DOF, 5'd9, 1'b0, 32'd0, 1'b1);
        rows[3]  = row_of({24'd0, instr_proto_pkg::ID_ACT_POS}, 32'd4,
                          instr_proto_pkg::CMD_ACT_POS, 5'd9, 1'b0, 32'd0, 1'b1);
        rows[4]  = row_of({24'd0, instr_proto_pkg::ID_MOT_CUE}, 32'd7,
                          instr_proto_pkg::CMD_MOT_CUE, 5'd16, 1'b1, 32'd2, 1'b1);
        rows[5]  = row_of({24'd0, instr_proto_pkg::ID_PLAYBACK}, 32'd8,
                          instr_proto_pkg::CMD_PLAYBACK, 5'd2, 1'b0, 32'd0, 1'b1);
        // unknown id followed by a normal packet
        rows[6]  = row_of(32'd50, 32'd9,
                          instr_proto_pkg::CMD_NONE, 5'd0, 1'b0, 32'd0, 1'b1);
        rows[7]  = row_of({24'd0, instr_proto_pkg::ID_EXT_MOT_CUE}, 32'd10,
                          instr_proto_pkg::CMD_EXT_MOT_CUE, 5'd17, 1'b0, 32'd0, 1'b1);
        rows[8]  = row_of({24'd0, instr_proto_pkg::ID_ACT_PVA}, 32'd11,
                          instr_proto_pkg::CMD_ACT_PVA, 5'd21, 1'b0, 32'd0, 1'b1);
        rows[9]  = row_of({24'd0, instr_proto_pkg::ID_DISCONNECT}, 32'd12,
                          instr_proto_pkg::CMD_NONE, 5'd0, 1'b0, 32'd0, 1'b0);
        rows[10] = row_of({24'd0, instr_proto_pkg::ID_ACT_POS}, 32'd13,
                          instr_proto_pkg::CMD_NONE, 5'd0, 1'b0, 32'd0, 1'b0);
        rows[11] = row_of({24'd0, instr_proto_pkg::ID_CONNECT}, 32'd20,
                          instr_proto_pkg::CMD_NONE, 5'd0, 1'b1, 32'd6, 1'b1);
        // upper id bits are ignored
        rows[12] = row_of(32'h0000_0165, 32'd21,
                          instr_proto_pkg::CMD_ACT_POS, 5'd9, 1'b0, 32'd0, 1'b1);
        rows[13] = row_of({24'd0, instr_proto_pkg::ID_DOF}, 32'hffff_ffff,
                          instr_proto_pkg::CMD_DOF, 5'd9, 1'b1, 32'hffff_ffe9, 1'b1);
        rows[14] = row_of({24'd0, instr_proto_pkg::ID_MOT_CUE}, 32'd0,
                          instr_proto_pkg::CMD_MOT_CUE, 5'd16, 1'b0, 32'd0, 1'b1);
    endtask

    task automatic run_frame(input frame_row_t r);
        instr_proto_pkg::word_t        payload [instr_proto_pkg::MAX_PAYLOAD];
        instr_core_pkg::payload_beat_t want;
        int                            beats;
        int                            gaps;
        int                            drain;
        logic                          seen_busy;
        mem[0] = 32'(instr_proto_pkg::HDR_WORDS) + 32'(r.n_beats);
        mem[1] = r.pkt_cnt;
        mem[2] = 32'h0000_0000;
        mem[3] = r.id_word;
        for (int k = 0; k < instr_proto_pkg::MAX_PAYLOAD; k++) begin
            seed = xorshift(seed);
            payload[5'(k)] = seed;
            mem[6'(instr_proto_pkg::HDR_WORDS + k)] = seed;
        end
        while (busy) begin
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        frame_ready <= 1'b1;
        @(posedge sys_clk);
        frame_ready <= 1'b0;
        beats     = 0;
        gaps      = 0;
        drain     = 0;
        seen_busy = 1'b0;
        // last beat leaves the router one cycle after busy drops
        while (drain < 2) begin
            @(negedge sys_clk);
            if (busy) begin
                seen_busy = 1'b1;
            end else if (seen_busy) begin
                drain++;
            end
            if (beat.valid) begin
                if (beats >= int'(r.n_beats)) begin
                    report_failure("payload beat seen beyond the expected count");
                end else begin
                    want.valid = 1'b1;
                    want.cmd   = r.cmd;
                    want.idx   = 5'(beats);
                    want.data  = payload[5'(beats)];
                    check_beat(want, beat);
                    beats++;
                end
            end
            if (gap.valid) begin
                gaps++;
                if (gaps > 1) begin
                    report_failure("more than one gap report for a single packet");
                end else begin
                    check_gap(r.gap, gap);
                end
            end
        end
        if (beats < int'(r.n_beats)) begin
            report_failure("packet ended with fewer payload beats than expected");
        end else if (r.gap.valid && gaps == 0) begin
            check_gap(r.gap, '0);
        end else begin
            check_flag("o_link_up", r.link_after, link_up);
        end
    endtask

    // --------------------
    initial begin
        seed = 32'hc3a10fdb;
        for (int a = 0; a < BUF_WORDS; a++) begin
            mem[6'(a)] = 32'hf111_0000 | 32'(a);
        end
        load_table();
        repeat (RST_CYCLES) @(posedge sys_clk);
        rst_n <= 1'b1;
        @(negedge sys_clk);
        check_flag("o_busy", 1'b0, busy);
        check_flag("o_beat.valid", 1'b0, beat.valid);
        check_flag("o_gap.valid", 1'b0, gap.valid);
        check_flag("o_link_up", 1'b0, link_up);
        if (rd_addr !== '0) begin
            report_mismatch("o_rd_addr", 32'd0, 32'(rd_addr));
        end
        for (int n = 0; n < N_ROWS; n++) begin
            run_frame(rows[4'(n)]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/frame_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_sequencer (
    input  wire logic                      i_sys_clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_frame_ready,
    input  wire instr_core_pkg::dispatch_t i_dispatch,
    output instr_proto_pkg::buf_addr_t     o_rd_addr,
    output instr_core_pkg::word_tag_t      o_tag,
    output logic                           o_busy
);

    instr_core_pkg::seq_state_t state_q;
    instr_core_pkg::seq_state_t state_d;
    instr_proto_pkg::word_idx_t cnt_q;
    instr_proto_pkg::word_idx_t cnt_d;
    instr_proto_pkg::word_idx_t plen_q;
    instr_core_pkg::word_tag_t  issue;
    logic                       start_payload;

    assign start_payload = i_dispatch.valid && (i_dispatch.cmd != instr_proto_pkg::CMD_NONE);

    // --------------------
    // next state and the tag of the address on the port
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        issue   = '0;
        unique case (state_q)
            instr_core_pkg::ST_IDLE: begin
                if (i_frame_ready) begin
                    state_d = instr_core_pkg::ST_HEADER;
                end
            end
            instr_core_pkg::ST_HEADER: begin
                issue.valid = 1'b1;
                issue.idx   = cnt_q;
                if (cnt_q == instr_proto_pkg::word_idx_t'(instr_proto_pkg::HDR_WORDS - 1)) begin
                    state_d = instr_core_pkg::ST_DECODE;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 5'd1;
                end
            end
            instr_core_pkg::ST_DECODE: begin
                // first payload address is already out, so it is read on the dispatch edge
                if (start_payload) begin
                    issue.valid      = 1'b1;
                    issue.is_payload = 1'b1;
                    state_d          = instr_core_pkg::ST_PAYLOAD;
                    cnt_d            = 5'd1;
                end else if (i_dispatch.valid) begin
                    state_d = instr_core_pkg::ST_IDLE;
                end
            end
            instr_core_pkg::ST_PAYLOAD: begin
                issue.valid      = 1'b1;
                issue.is_payload = 1'b1;
                issue.idx        = cnt_q;
                if (cnt_q == plen_q - 5'd1) begin
                    state_d = instr_core_pkg::ST_IDLE;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 5'd1;
                end
            end
            default: begin
                state_d = instr_core_pkg::ST_IDLE;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= instr_core_pkg::ST_IDLE;
            cnt_q   <= '0;
            plen_q  <= '0;
            o_tag   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            o_tag   <= issue;
            if (state_q == instr_core_pkg::ST_DECODE && start_payload) begin
                plen_q <= instr_proto_pkg::payload_words(i_dispatch.cmd);
            end
        end
    end

    // --------------------
    // read address follows the word count
    assign o_rd_addr = (state_q == instr_core_pkg::ST_DECODE ||
                        state_q == instr_core_pkg::ST_PAYLOAD)
                     ? instr_proto_pkg::buf_addr_t'(instr_proto_pkg::HDR_WORDS)
                       + instr_proto_pkg::buf_addr_t'(cnt_q)
                     : instr_proto_pkg::buf_addr_t'(cnt_q);

    assign o_busy = (state_q != instr_core_pkg::ST_IDLE);

endmodule

`default_nettype wire

// ==== logic/header_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module header_decoder (
    input  wire logic                      i_sys_clk,
    input  wire logic                      i_rst_n,
    input  wire instr_core_pkg::word_tag_t i_tag,
    input  wire instr_proto_pkg::word_t    i_rd_data,
    output instr_core_pkg::dispatch_t      o_dispatch,
    output instr_proto_pkg::cmd_t          o_cmd,
    output logic                           o_link_up
);

    instr_proto_pkg::instr_id_t id_byte;
    instr_proto_pkg::cmd_t      motion_cmd;
    logic                       id_word;
    logic                       is_connect;
    logic                       is_disconnect;
    logic                       accept;

    assign id_word = i_tag.valid && !i_tag.is_payload &&
                     (i_tag.idx == instr_proto_pkg::HDR_IDX_ID);

    assign id_byte       = i_rd_data[7:0];
    assign is_connect    = (id_byte == instr_proto_pkg::ID_CONNECT);
    assign is_disconnect = (id_byte == instr_proto_pkg::ID_DISCONNECT);

    // --------------------
    // id to motion command
    always_comb begin
        case (id_byte)
            instr_proto_pkg::ID_DOF:         motion_cmd = instr_proto_pkg::CMD_DOF;
            instr_proto_pkg::ID_ACT_POS:     motion_cmd = instr_proto_pkg::CMD_ACT_POS;
            instr_proto_pkg::ID_MOT_CUE:     motion_cmd = instr_proto_pkg::CMD_MOT_CUE;
            instr_proto_pkg::ID_PLAYBACK:    motion_cmd = instr_proto_pkg::CMD_PLAYBACK;
            instr_proto_pkg::ID_EXT_MOT_CUE: motion_cmd = instr_proto_pkg::CMD_EXT_MOT_CUE;
            instr_proto_pkg::ID_ACT_PVA:     motion_cmd = instr_proto_pkg::CMD_ACT_PVA;
            default:                         motion_cmd = instr_proto_pkg::CMD_NONE;
        endcase
    end

    // motion data only counts while connected
    assign accept = o_link_up && (motion_cmd != instr_proto_pkg::CMD_NONE);

    // --------------------
    // dispatch pulse, link state, held command
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dispatch.valid <= 1'b0;
            o_dispatch.cmd   <= instr_proto_pkg::CMD_NONE;
            o_cmd            <= instr_proto_pkg::CMD_NONE;
            o_link_up        <= 1'b0;
        end else begin
            o_dispatch.valid <= id_word;
            o_dispatch.cmd   <= accept ? motion_cmd : instr_proto_pkg::CMD_NONE;
            if (id_word) begin
                if (is_connect) begin
                    o_link_up <= 1'b1;
                end else if (is_disconnect) begin
                    o_link_up <= 1'b0;
                end
                // kept for the router until the next accepted command
                if (accept) begin
                    o_cmd <= motion_cmd;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_core_pkg.sv ====
`default_nettype none

package instr_core_pkg;

    // --------------------
    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_DECODE,
        ST_PAYLOAD
    } seq_state_t;

    // marks the word currently on the read data port
    typedef struct packed {
        logic                       valid;
        logic                       is_payload;
        instr_proto_pkg::word_idx_t idx;
    } word_tag_t;

    // one-cycle decision from the header decoder
    typedef struct packed {
        logic                  valid;
        instr_proto_pkg::cmd_t cmd;
    } dispatch_t;

    typedef struct packed {
        logic                       valid;
        instr_proto_pkg::cmd_t      cmd;
        instr_proto_pkg::word_idx_t idx;
        instr_proto_pkg::word_t     data;
    } payload_beat_t;

    // frames lost between two consecutive packets
    typedef struct packed {
        logic                   valid;
        instr_proto_pkg::word_t missing;
    } gap_report_t;

endpackage

`default_nettype wire

// ==== logic/instr_parse_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_parse_top (
    input  wire logic                      i_sys_clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_frame_ready,
    output instr_proto_pkg::buf_addr_t     o_rd_addr,
    input  wire instr_proto_pkg::word_t    i_rd_data,
    output logic                           o_busy,
    output logic                           o_link_up,
    output instr_core_pkg::payload_beat_t  o_beat,
    output instr_core_pkg::gap_report_t    o_gap
);

    instr_core_pkg::word_tag_t tag;
    instr_core_pkg::dispatch_t dispatch;
    instr_proto_pkg::cmd_t     cur_cmd;

    frame_sequencer u_seq (
        .i_sys_clk     (i_sys_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_ready (i_frame_ready),
        .i_dispatch    (dispatch),
        .o_rd_addr     (o_rd_addr),
        .o_tag         (tag),
        .o_busy        (o_busy)
    );

    header_decoder u_hdr (
        .i_sys_clk  (i_sys_clk),
        .i_rst_n    (i_rst_n),
        .i_tag      (tag),
        .i_rd_data  (i_rd_data),
        .o_dispatch (dispatch),
        .o_cmd      (cur_cmd),
        .o_link_up  (o_link_up)
    );

    seq_gap_monitor u_gap (
        .i_sys_clk (i_sys_clk),
        .i_rst_n   (i_rst_n),
        .i_tag     (tag),
        .i_rd_data (i_rd_data),
        .o_gap     (o_gap)
    );

    payload_router u_route (
        .i_sys_clk (i_sys_clk),
        .i_rst_n   (i_rst_n),
        .i_tag     (tag),
        .i_rd_data (i_rd_data),
        .i_cmd     (cur_cmd),
        .o_beat    (o_beat)
    );

endmodule

`default_nettype wire

// ==== logic/instr_proto_pkg.sv ====
`default_nettype none

package instr_proto_pkg;

    // --------------------
    // word and address types

    typedef logic [31:0] word_t;
    typedef logic [15:0] buf_addr_t;
    typedef logic [7:0]  instr_id_t;

    // position inside the header or inside the payload
    typedef logic [4:0]  word_idx_t;

    // --------------------
    // header layout

    // length, packet counter, reserved, instruction id
    localparam int HDR_WORDS = 4;

    localparam word_idx_t HDR_IDX_PKG_CNT = 5'd1;
    localparam word_idx_t HDR_IDX_ID      = 5'd3;

    // only the low byte of the id word is decoded
    localparam instr_id_t ID_CONNECT     = 8'd1;
    localparam instr_id_t ID_DISCONNECT  = 8'd2;
    localparam instr_id_t ID_DOF         = 8'd100;
    localparam instr_id_t ID_ACT_POS     = 8'd101;
    localparam instr_id_t ID_MOT_CUE     = 8'd102;
    localparam instr_id_t ID_PLAYBACK    = 8'd103;
    localparam instr_id_t ID_EXT_MOT_CUE = 8'd104;
    localparam instr_id_t ID_ACT_PVA     = 8'd105;

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_DOF,
        CMD_ACT_POS,
        CMD_MOT_CUE,
        CMD_PLAYBACK,
        CMD_EXT_MOT_CUE,
        CMD_ACT_PVA
    } cmd_t;

    // --------------------
    // payload sizes in command order from CMD_DOF
    localparam word_idx_t PAYLOAD_WORDS [6] = '{5'd9, 5'd9, 5'd16, 5'd2, 5'd17, 5'd21};
    localparam int        MAX_PAYLOAD       = 21;

    function automatic word_idx_t payload_words(cmd_t cmd);
        word_idx_t n;
        n = '0;
        if (cmd != CMD_NONE) begin
            n = PAYLOAD_WORDS[int'(cmd) - 1];
        end
        return n;
    endfunction

endpackage

`default_nettype wire

// ==== logic/payload_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module payload_router (
    input  wire logic                      i_sys_clk,
    input  wire logic                      i_rst_n,
    input  wire instr_core_pkg::word_tag_t i_tag,
    input  wire instr_proto_pkg::word_t    i_rd_data,
    input  wire instr_proto_pkg::cmd_t     i_cmd,
    output instr_core_pkg::payload_beat_t  o_beat
);

    instr_proto_pkg::cmd_t      beat_cmd;
    instr_proto_pkg::word_idx_t beat_idx;
    instr_proto_pkg::word_t     beat_data;
    logic                       beat_valid;
    logic                       payload_word;

    assign payload_word = i_tag.valid && i_tag.is_payload;

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= payload_word;
        end
    end

    // tag and data travel together into one beat
    always_ff @(posedge i_sys_clk) begin
        if (payload_word) begin
            beat_cmd  <= i_cmd;
            beat_idx  <= i_tag.idx;
            beat_data <= i_rd_data;
        end
    end

    assign o_beat = '{valid: beat_valid, cmd: beat_cmd, idx: beat_idx, data: beat_data};

endmodule

`default_nettype wire

// ==== logic/seq_gap_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module seq_gap_monitor (
    input  wire logic                      i_sys_clk,
    input  wire logic                      i_rst_n,
    input  wire instr_core_pkg::word_tag_t i_tag,
    input  wire instr_proto_pkg::word_t    i_rd_data,
    output instr_core_pkg::gap_report_t    o_gap
);

    instr_proto_pkg::word_t prev_cnt;
    instr_proto_pkg::word_t missing;
    logic                   cnt_word;
    logic                   gap_valid;

    assign cnt_word = i_tag.valid && !i_tag.is_payload &&
                      (i_tag.idx == instr_proto_pkg::HDR_IDX_PKG_CNT);

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prev_cnt  <= '0;
            gap_valid <= 1'b0;
        end else begin
            gap_valid <= cnt_word && (i_rd_data != prev_cnt + 32'd1);
            if (cnt_word) begin
                prev_cnt <= i_rd_data;
            end
        end
    end

    // wraps modulo 2^32
    always_ff @(posedge i_sys_clk) begin
        if (cnt_word) begin
            missing <= i_rd_data - prev_cnt - 32'd1;
        end
    end

    assign o_gap = '{valid: gap_valid, missing: missing};

endmodule

`default_nettype wire

// ==== sources.f ====
logic/instr_proto_pkg.sv
logic/instr_core_pkg.sv
logic/frame_sequencer.sv
logic/header_decoder.sv
logic/seq_gap_monitor.sv
logic/payload_router.sv
logic/instr_parse_top.sv
dv/instr_parse_tb.sv
